/* source/execPkg.sv */
`default_nettype none

package execPkg;

    // opcodes from the main controller
    typedef enum logic [3:0] {
        DC        = 4'b0000, // decode the function field
        ADD_I     = 4'b0001,
        SUB_I     = 4'b0010,
        OR_I      = 4'b0011,
        AND_I     = 4'b0100,
        XOR_I     = 4'b0101,
        NOR_I     = 4'b0110,
        ADDU_I    = 4'b0111,
        SUBU_I    = 4'b1000,
        MULTU_I   = 4'b1001,
        SLT_I     = 4'b1010,
        SLTU_I    = 4'b1011,
        MUL_OP    = 4'b1100, // multiply group, see mulFunctE
        SEBSEH_OP = 4'b1101  // sign extension group
    } aluOpE;

    // SPECIAL function field
    typedef enum logic [5:0] {
        F_SLL   = 6'b000000,
        F_SRL   = 6'b000010,
        F_SRA   = 6'b000011,
        F_SLLV  = 6'b000100,
        F_ROTRV = 6'b000110,
        F_SRAV  = 6'b000111,
        F_MOVZ  = 6'b001010,
        F_MOVN  = 6'b001011,
        F_MULT  = 6'b011000,
        F_MULTU = 6'b011001,
        F_ADD   = 6'b100000,
        F_ADDU  = 6'b100001,
        F_SUB   = 6'b100010,
        F_AND   = 6'b100100,
        F_OR    = 6'b100101,
        F_XOR   = 6'b100110,
        F_NOR   = 6'b100111,
        F_SLT   = 6'b101010,
        F_SLTU  = 6'b101011
    } functE;

    // function field under MUL_OP, codes overlap functE
    typedef enum logic [5:0] {
        FM_MADD = 6'b000000,
        FM_MUL  = 6'b000010,
        FM_MSUB = 6'b000100
    } mulFunctE;

    typedef enum logic [4:0] {
        ADD    = 5'b00000,
        ADDU   = 5'b00001,
        SUB    = 5'b00010,
        MULT   = 5'b00011,
        MULTU  = 5'b00100,
        AND    = 5'b00101,
        OR     = 5'b00110,
        NOR    = 5'b00111,
        XOR    = 5'b01000,
        SLL    = 5'b01001,
        SRL    = 5'b01010,
        SLLV   = 5'b01011,
        SLT    = 5'b01100,
        MOVN   = 5'b01101,
        MOVZ   = 5'b01110,
        ROTRV  = 5'b01111,
        SRA    = 5'b10000,
        SRAV   = 5'b10001,
        SLTU   = 5'b10010,
        MUL    = 5'b10011,
        MADD   = 5'b10100,
        MSUB   = 5'b10101,
        SEBSEH = 5'b10110
    } aluCtrlE;

    typedef struct packed {
        aluOpE       aluOp;
        logic [5:0]  funct; // read as functE or mulFunctE
        logic [4:0]  shamt;
    } instrT;

    typedef struct packed {
        logic [31:0] result;
        logic        writeEn; // low when movn/movz condition fails
    } aluResultT;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat;
    } wbReqT;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbRspT;

    typedef enum logic [2:0] {
        REG_A      = 3'd0,
        REG_B      = 3'd1,
        REG_INSTR  = 3'd2, // write issues the instruction
        REG_RESULT = 3'd3,
        REG_HI     = 3'd4,
        REG_LO     = 3'd5
    } regAddrE;

endpackage

`default_nettype wire

/* source/aluDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module aluDecoder import execPkg::*; (
    input  wire     clk,
    input  wire     rstN,
    input  instrT   instr,
    output aluCtrlE aluCtrl
);

    always_comb begin
        aluCtrl = ADD; // unknown codes fall back to add
        if (instr.aluOp == DC) begin
            case (functE'(instr.funct))
                F_ADD:   aluCtrl = ADD;
                F_ADDU:  aluCtrl = ADDU;
                F_SUB:   aluCtrl = SUB;
                F_MULT:  aluCtrl = MULT;
                F_MULTU: aluCtrl = MULTU;
                F_AND:   aluCtrl = AND;
                F_OR:    aluCtrl = OR;
                F_NOR:   aluCtrl = NOR;
                F_XOR:   aluCtrl = XOR;
                F_SLL:   aluCtrl = SLL;
                F_SRL:   aluCtrl = SRL;
                F_SLLV:  aluCtrl = SLLV;
                F_SLT:   aluCtrl = SLT;
                F_MOVN:  aluCtrl = MOVN;
                F_MOVZ:  aluCtrl = MOVZ;
                F_ROTRV: aluCtrl = ROTRV;
                F_SRA:   aluCtrl = SRA;
                F_SRAV:  aluCtrl = SRAV;
                F_SLTU:  aluCtrl = SLTU;
                default: aluCtrl = ADD;
            endcase
        end else begin
            case (instr.aluOp)
                ADD_I:   aluCtrl = ADD;
                SUB_I:   aluCtrl = SUB;
                OR_I:    aluCtrl = OR;
                AND_I:   aluCtrl = AND;
                XOR_I:   aluCtrl = XOR;
                NOR_I:   aluCtrl = NOR;
                ADDU_I:  aluCtrl = ADDU;
                SUBU_I:  aluCtrl = SUB;   // wraps the same as subu
                MULTU_I: aluCtrl = MULTU;
                SLT_I:   aluCtrl = SLT;
                SLTU_I:  aluCtrl = SLTU;
                MUL_OP: begin
                    case (mulFunctE'(instr.funct))
                        FM_MUL:  aluCtrl = MUL;
                        FM_MADD: aluCtrl = MADD;
                        FM_MSUB: aluCtrl = MSUB;
                        default: aluCtrl = ADD;
                    endcase
                end
                SEBSEH_OP: aluCtrl = SEBSEH; // seb/seh picked by shamt in the ALU
                default:   aluCtrl = ADD;
            endcase
        end
    end

    // instruction register is cleared by reset, so the code must stay defined
    aluCtrlKnown: assert property (
        @(posedge clk) disable iff (!rstN) !$isunknown(aluCtrl)
    ) else $error("aluCtrl unknown");

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu import execPkg::*; (
    input  aluCtrlE     aluCtrl,
    input  instrT       instr,
    input  wire  [31:0] opA,
    input  wire  [31:0] opB,
    output aluResultT   aluOut
);

    logic [4:0]  shiftVar; // variable shift amount from A
    logic [63:0] rotWide;

    assign shiftVar = opA[4:0];
    assign rotWide  = {opB, opB} >> shiftVar;

    always_comb begin
        aluOut.result  = 32'd0;
        aluOut.writeEn = 1'b1;
        case (aluCtrl)
            ADD, ADDU: aluOut.result = opA + opB; // no overflow trap
            SUB:       aluOut.result = opA - opB;
            AND:       aluOut.result = opA & opB;
            OR:        aluOut.result = opA | opB;
            NOR:       aluOut.result = ~(opA | opB);
            XOR:       aluOut.result = opA ^ opB;
            SLL:       aluOut.result = opB << instr.shamt;
            SRL:       aluOut.result = opB >> instr.shamt;
            SRA:       aluOut.result = $signed(opB) >>> instr.shamt;
            SLLV:      aluOut.result = opB << shiftVar;
            SRAV:      aluOut.result = $signed(opB) >>> shiftVar;
            ROTRV:     aluOut.result = rotWide[31:0];
            SLT:       aluOut.result = {31'd0, $signed(opA) < $signed(opB)};
            SLTU:      aluOut.result = {31'd0, opA < opB};
            MOVN: begin
                aluOut.result  = opA;
                aluOut.writeEn = (opB != 32'd0);
            end
            MOVZ: begin
                aluOut.result  = opA;
                aluOut.writeEn = (opB == 32'd0);
            end
            SEBSEH: begin
                if (instr.shamt[3]) begin // seh
                    aluOut.result = {{16{opB[15]}}, opB[15:0]};
                end else begin
                    aluOut.result = {{24{opB[7]}}, opB[7:0]};
                end
            end
            MUL:       aluOut.result = opA * opB; // low word is sign independent
            MULT, MULTU, MADD, MSUB: begin
                aluOut.result  = 32'd0; // these only touch HI/LO
                aluOut.writeEn = 1'b0;
            end
            default:   aluOut.result = opA + opB;
        endcase
    end

endmodule

`default_nettype wire

/* source/hiLoUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module hiLoUnit import execPkg::*; (
    input  wire         clk,
    input  wire         rstN,
    input  wire         issue,
    input  aluCtrlE     aluCtrl,
    input  wire  [31:0] opA,
    input  wire  [31:0] opB,
    output logic [31:0] hi,
    output logic [31:0] lo
);

    logic signed [63:0] prodS;
    logic        [63:0] prodU;
    logic        [63:0] hiLo; // HI in the upper word

    assign prodS = $signed(opA) * $signed(opB);
    assign prodU = {32'd0, opA} * {32'd0, opB};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hiLo <= 64'd0;
        end else if (issue) begin
            case (aluCtrl)
                MULT:    hiLo <= prodS;
                MULTU:   hiLo <= prodU;
                MADD:    hiLo <= hiLo + prodS; // accumulate
                MSUB:    hiLo <= hiLo - prodS;
                default: hiLo <= hiLo;
            endcase
        end
    end

    assign hi = hiLo[63:32];
    assign lo = hiLo[31:0];

endmodule

`default_nettype wire

/* source/execCtrl.sv */
`timescale 1ns/1ns
`default_nettype none

module execCtrl import execPkg::*; (
    input  wire         clk,
    input  wire         rstN,
    input  wbReqT       wbReq,
    output wbRspT       wbRsp,
    output instrT       instr,
    output logic [31:0] opA,
    output logic [31:0] opB,
    input  aluResultT   aluOut,
    input  wire  [31:0] hi,
    input  wire  [31:0] lo,
    output logic        issue
);

    typedef enum logic {IDLE, ACK} stateE;

    stateE       state;
    logic [31:0] resultReg;
    logic [31:0] rdData;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= IDLE;
            issue     <= 1'b0;
            opA       <= 32'd0;
            opB       <= 32'd0;
            instr     <= '0;
            resultReg <= 32'd0;
            rdData    <= 32'd0;
        end else begin
            issue <= 1'b0; // one-cycle pulse
            if (issue && aluOut.writeEn) begin
                resultReg <= aluOut.result;
            end
            case (state)
                IDLE: begin
                    if (wbReq.cyc && wbReq.stb) begin
                        state  <= ACK;
                        rdData <= 32'd0;
                        if (wbReq.we) begin
                            case (regAddrE'(wbReq.adr))
                                REG_A: opA <= wbReq.dat;
                                REG_B: opB <= wbReq.dat;
                                REG_INSTR: begin
                                    instr <= instrT'(wbReq.dat[14:0]);
                                    issue <= 1'b1; // executes on next edge
                                end
                                default: ; // read-only or unmapped
                            endcase
                        end else begin
                            case (regAddrE'(wbReq.adr))
                                REG_RESULT: rdData <= resultReg;
                                REG_HI:     rdData <= hi;
                                REG_LO:     rdData <= lo;
                                default:    rdData <= 32'd0;
                            endcase
                        end
                    end
                end
                ACK:     state <= IDLE; // forces a gap before the next ack
                default: state <= IDLE;
            endcase
        end
    end

    assign wbRsp.ack = (state == ACK);
    assign wbRsp.dat = rdData;

    ackFollowsReq: assert property (
        @(posedge clk) disable iff (!rstN) wbRsp.ack |-> wbReq.cyc && wbReq.stb
    ) else $error("ack without request");

    ackSingleCycle: assert property (
        @(posedge clk) disable iff (!rstN) wbRsp.ack |=> !wbRsp.ack
    ) else $error("ack held two cycles");

endmodule

`default_nettype wire

/* source/execUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module execUnit import execPkg::*; (
    input  wire   clk,
    input  wire   rstN,
    input  wbReqT wbReq,
    output wbRspT wbRsp
);

    instrT       instr;
    aluCtrlE     aluCtrl;
    aluResultT   aluOut;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] hi;
    logic [31:0] lo;
    logic        issue; // from the REG_INSTR write ack

    execCtrl execCtrl_i (
        .clk    (clk),
        .rstN   (rstN),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp),
        .instr  (instr),
        .opA    (opA),
        .opB    (opB),
        .aluOut (aluOut),
        .hi     (hi),
        .lo     (lo),
        .issue  (issue)
    );

    aluDecoder aluDecoder_i (
        .clk     (clk),
        .rstN    (rstN),
        .instr   (instr),
        .aluCtrl (aluCtrl)
    );

    alu alu_i (
        .aluCtrl (aluCtrl),
        .instr   (instr),
        .opA     (opA),
        .opB     (opB),
        .aluOut  (aluOut)
    );

    hiLoUnit hiLoUnit_i (
        .clk     (clk),
        .rstN    (rstN),
        .issue   (issue),
        .aluCtrl (aluCtrl),
        .opA     (opA),
        .opB     (opB),
        .hi      (hi),
        .lo      (lo)
    );

endmodule

`default_nettype wire

/* test/clockGen.sv */
`timescale 1ns/1ns
`default_nettype none

module clockGen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk; // 40 ns period

endmodule

`default_nettype wire

/* test/execUnitTb.sv */
`timescale 1ns/1ns
`default_nettype none

module execUnitTb import execPkg::*; ();

    typedef struct packed {
        logic [3:0]  aluOp;
        logic [5:0]  funct;
        logic [4:0]  shamt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expRes;
        logic [31:0] expHi;
        logic [31:0] expLo;
    } vecT;

    wire   clk;
    logic  rstN;
    wbReqT wbReq;
    wbRspT wbRsp;

    vecT         vecs [$];
    int          errors = 0;
    int          cycles = 0;
    int          cycleLimit = 1000000; // replaced once the table is built
    logic [31:0] rdVal;

    clockGen clockGen_i (
        .clk (clk)
    );

    execUnit execUnit_i (
        .clk   (clk),
        .rstN  (rstN),
        .wbReq (wbReq),
        .wbRsp (wbRsp)
    );

    task automatic addVec(input logic [3:0] op, input logic [5:0] fn, input logic [4:0] sh,
                          input logic [31:0] a, input logic [31:0] b, input logic [31:0] res,
                          input logic [31:0] hi, input logic [31:0] lo);
        vecs.push_back(vecT'{op, fn, sh, a, b, res, hi, lo});
    endtask

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic wbWrite(input logic [2:0] adr, input logic [31:0] dat);
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        do @(negedge clk); while (!wbRsp.ack);
        @(negedge clk); // request held until the ack edge has passed
        wbReq = '0;
    endtask

    task automatic wbRead(input logic [2:0] adr, output logic [31:0] dat);
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'd0};
        do @(negedge clk); while (!wbRsp.ack);
        dat = wbRsp.dat; // stable half a cycle after the ack edge
        @(negedge clk);
        wbReq = '0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        rstN  = 1'b0;
        wbReq = '0;

        // R-type through DC
        addVec(DC, F_ADD,   5'd0, 32'h00000005, 32'h00000007, 32'h0000000C, 32'h0, 32'h0);
        addVec(DC, F_ADDU,  5'd0, 32'hFFFFFFFF, 32'h00000002, 32'h00000001, 32'h0, 32'h0);
        addVec(DC, F_SUB,   5'd0, 32'h00000003, 32'h00000005, 32'hFFFFFFFE, 32'h0, 32'h0);
        addVec(DC, F_AND,   5'd0, 32'hF0F0F0F0, 32'hFF00FF00, 32'hF000F000, 32'h0, 32'h0);
        addVec(DC, F_OR,    5'd0, 32'hF0F0F0F0, 32'hFF00FF00, 32'hFFF0FFF0, 32'h0, 32'h0);
        addVec(DC, F_NOR,   5'd0, 32'hF0F0F0F0, 32'hFF00FF00, 32'h000F000F, 32'h0, 32'h0);
        addVec(DC, F_XOR,   5'd0, 32'hF0F0F0F0, 32'hFF00FF00, 32'h0FF00FF0, 32'h0, 32'h0);
        addVec(DC, F_SLT,   5'd0, 32'hFFFFFFFF, 32'h00000001, 32'h00000001, 32'h0, 32'h0);
        addVec(DC, F_SLTU,  5'd0, 32'hFFFFFFFF, 32'h00000001, 32'h00000000, 32'h0, 32'h0);
        addVec(DC, 6'h3F,   5'd0, 32'h0000000A, 32'h00000014, 32'h0000001E, 32'h0, 32'h0);
        // immediate opcodes, B comes pre-extended
        addVec(ADD_I,  6'd0, 5'd0, 32'h00000005, 32'h00000007, 32'h0000000C, 32'h0, 32'h0);
        addVec(SUB_I,  6'd0, 5'd0, 32'h00000003, 32'h00000005, 32'hFFFFFFFE, 32'h0, 32'h0);
        addVec(OR_I,   6'd0, 5'd0, 32'hF0F0F0F0, 32'hFF00FF00, 32'hFFF0FFF0, 32'h0, 32'h0);
        addVec(AND_I,  6'd0, 5'd0, 32'hF0F0F0F0, 32'hFF00FF00, 32'hF000F000, 32'h0, 32'h0);
        addVec(XOR_I,  6'd0, 5'd0, 32'hF0F0F0F0, 32'hFF00FF00, 32'h0FF00FF0, 32'h0, 32'h0);
        addVec(NOR_I,  6'd0, 5'd0, 32'hF0F0F0F0, 32'hFF00FF00, 32'h000F000F, 32'h0, 32'h0);
        addVec(ADDU_I, 6'd0, 5'd0, 32'hFFFFFFFF, 32'h00000002, 32'h00000001, 32'h0, 32'h0);
        addVec(SUBU_I, 6'd0, 5'd0, 32'h00000000, 32'h00000001, 32'hFFFFFFFF, 32'h0, 32'h0);
        addVec(SLT_I,  6'd0, 5'd0, 32'hFFFFFFFF, 32'h00000001, 32'h00000001, 32'h0, 32'h0);
        addVec(SLTU_I, 6'd0, 5'd0, 32'hFFFFFFFF, 32'h00000001, 32'h00000000, 32'h0, 32'h0);
        // shifts, variable ones use A[4:0] only
        addVec(DC, F_SLL,   5'd4, 32'h00000000, 32'h000000F1, 32'h00000F10, 32'h0, 32'h0);
        addVec(DC, F_SRL,   5'd8, 32'h00000000, 32'h80001200, 32'h00800012, 32'h0, 32'h0);
        addVec(DC, F_SRA,   5'd8, 32'h00000000, 32'h80001200, 32'hFF800012, 32'h0, 32'h0);
        addVec(DC, F_SLLV,  5'd0, 32'h00000023, 32'h00000001, 32'h00000008, 32'h0, 32'h0);
        addVec(DC, F_SRAV,  5'd0, 32'h00000004, 32'hF0000000, 32'hFF000000, 32'h0, 32'h0);
        addVec(DC, F_ROTRV, 5'd0, 32'h00000001, 32'h80000001, 32'hC0000000, 32'h0, 32'h0);
        // movz with B nonzero keeps the movn result
        addVec(DC, F_MOVN,  5'd0, 32'h12345678, 32'h00000001, 32'h12345678, 32'h0, 32'h0);
        addVec(DC, F_MOVZ,  5'd0, 32'hAAAAAAAA, 32'h00000001, 32'h12345678, 32'h0, 32'h0);
        addVec(SEBSEH_OP, 6'd0, 5'd0, 32'h0, 32'h00000080, 32'hFFFFFF80, 32'h0, 32'h0);
        addVec(SEBSEH_OP, 6'd0, 5'd8, 32'h0, 32'h00018000, 32'hFFFF8000, 32'h0, 32'h0);
        // HI/LO sequence, result register holds the seh value
        addVec(DC, F_MULT,     5'd0, 32'hFFFFFFFE, 32'h00000003, 32'hFFFF8000,
               32'hFFFFFFFF, 32'hFFFFFFFA);
        addVec(MUL_OP, FM_MADD, 5'd0, 32'h00000004, 32'h00000005, 32'hFFFF8000,
               32'h00000000, 32'h0000000E);
        addVec(MUL_OP, FM_MSUB, 5'd0, 32'h00000002, 32'h0000000A, 32'hFFFF8000,
               32'hFFFFFFFF, 32'hFFFFFFFA);
        addVec(DC, F_MULTU,    5'd0, 32'hFFFFFFFF, 32'hFFFFFFFF, 32'hFFFF8000,
               32'hFFFFFFFE, 32'h00000001);
        addVec(MULTU_I, 6'd0,  5'd0, 32'hFFFFFFFF, 32'h00000002, 32'hFFFF8000,
               32'h00000001, 32'hFFFFFFFE);
        addVec(MUL_OP, FM_MUL,  5'd0, 32'hFFFFFFFD, 32'h00000007, 32'hFFFFFFEB,
               32'h00000001, 32'hFFFFFFFE);

        cycleLimit = vecs.size() * 6 * 4 + 50;

        repeat (8) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        // state right after reset and bus corner cases
        wbRead(REG_RESULT, rdVal);
        checkEq("result after reset", rdVal, 32'h0);
        wbRead(REG_HI, rdVal);
        checkEq("hi after reset", rdVal, 32'h0);
        wbRead(REG_LO, rdVal);
        checkEq("lo after reset", rdVal, 32'h0);
        wbWrite(REG_RESULT, 32'hDEADBEEF); // read-only, must be ignored
        wbRead(REG_RESULT, rdVal);
        checkEq("result after write to read-only", rdVal, 32'h0);
        wbRead(3'd7, rdVal);
        checkEq("unmapped read", rdVal, 32'h0);

        foreach (vecs[i]) begin
            wbWrite(REG_A, vecs[i].a);
            wbWrite(REG_B, vecs[i].b);
            wbWrite(REG_INSTR, {17'd0, vecs[i].aluOp, vecs[i].funct, vecs[i].shamt});
            wbRead(REG_RESULT, rdVal);
            checkEq($sformatf("entry %0d result", i), rdVal, vecs[i].expRes);
            wbRead(REG_HI, rdVal);
            checkEq($sformatf("entry %0d hi", i), rdVal, vecs[i].expHi);
            wbRead(REG_LO, rdVal);
            checkEq($sformatf("entry %0d lo", i), rdVal, vecs[i].expLo);
        end

        $display("%0d entries run, %0d errors", vecs.size(), errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
source/execPkg.sv
source/aluDecoder.sv
source/alu.sv
source/hiLoUnit.sv
source/execCtrl.sv
source/execUnit.sv
test/clockGen.sv
test/execUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the execute-unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module execUnitTb -o simv
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

simOut=$(./obj_dir/simv)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
